// ==== project.f ====
+incdir+sim
verilog/isaPkg.sv
verilog/hazardPkg.sv
verilog/writeDecode.sv
verilog/useDecode.sv
verilog/hazardPipe.sv
verilog/stallCheck.sv
verilog/forwardSelect.sv
verilog/hazardUnit.sv
sim/hazardUnitTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --top-module hazardUnitTb -f project.f -o simHazard \
	&& ./obj_dir/simHazard > sim.log \
	; cat sim.log 2>/dev/null

grep -q "STATUS: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sim/hazardRef.svh ====
`ifndef HAZARD_REF_SVH
`define HAZARD_REF_SVH

//////////////////////////////
// Software copy of E, M and W
//////////////////////////////
isaPkg::regNumT  refDestE;
isaPkg::regNumT  refDestM;
isaPkg::regNumT  refDestW;
isaPkg::regNumT  refRsE;
isaPkg::regNumT  refRtE;
hazardPkg::tnewT refTnewE;
hazardPkg::tnewT refTnewM;

// Producer side of an instruction with Tnew as seen in E
task automatic producerInfo(input isaPkg::instrT instr, output isaPkg::regNumT dest,
		output hazardPkg::tnewT tnew);
	logic [5:0] op;
	logic [5:0] fn;
	op = instr[31:26];
	fn = instr[5:0];
	dest = 5'd0;
	tnew = 2'd0;
	if (op == isaPkg::opR && (fn == isaPkg::fnAddu || fn == isaPkg::fnSubu ||
			fn == isaPkg::fnAnd || fn == isaPkg::fnOr || fn == isaPkg::fnSlt ||
			fn == isaPkg::fnSltu)) begin
		dest = instr[15:11];
		tnew = 2'd1;
	end else if (op == isaPkg::opOri || op == isaPkg::opAddi || op == isaPkg::opAndi ||
			op == isaPkg::opLui) begin
		dest = instr[20:16];
		tnew = 2'd1;
	end else if (op == isaPkg::opLw || op == isaPkg::opLb || op == isaPkg::opLh) begin
		dest = instr[20:16];
		tnew = 2'd2;
	end else if (op == isaPkg::opJal) begin
		dest = 5'd31;
	end
endtask

// Consumer side of an instruction
// Tuse 3 marks an operand that is not read
task automatic consumerUse(input isaPkg::instrT instr, output hazardPkg::tuseT useRs,
		output hazardPkg::tuseT useRt);
	logic [5:0] op;
	logic [5:0] fn;
	op = instr[31:26];
	fn = instr[5:0];
	useRs = 2'd3;
	useRt = 2'd3;
	if (op == isaPkg::opBeq) begin
		useRs = 2'd0;
		useRt = 2'd0;
	end else if (op == isaPkg::opR && fn == isaPkg::fnJr) begin
		useRs = 2'd0;
	end else if (op == isaPkg::opR && (fn == isaPkg::fnAddu || fn == isaPkg::fnSubu ||
			fn == isaPkg::fnAnd || fn == isaPkg::fnOr || fn == isaPkg::fnSlt ||
			fn == isaPkg::fnSltu)) begin
		useRs = 2'd1;
		useRt = 2'd1;
	end else if (op == isaPkg::opOri || op == isaPkg::opAddi || op == isaPkg::opAndi ||
			op == isaPkg::opLw || op == isaPkg::opLb || op == isaPkg::opLh) begin
		useRs = 2'd1;
	end else if (op == isaPkg::opSw || op == isaPkg::opSb || op == isaPkg::opSh) begin
		useRs = 2'd1;
		useRt = 2'd2;
	end
endtask

function automatic logic operandWaits(input isaPkg::regNumT src, input hazardPkg::tuseT tuse);
	if (src == 5'd0 || tuse == 2'd3)
		return 1'b0;
	return (src == refDestE && tuse < refTnewE) || (src == refDestM && tuse < refTnewM);
endfunction

// Newest stage whose result already exists
function automatic hazardPkg::fwdSelT newestSource(input isaPkg::regNumT src,
		input logic fromD);
	if (src == 5'd0)
		return hazardPkg::fwdReg;
	if (fromD && src == refDestE && refTnewE == 2'd0)
		return hazardPkg::fwdE;
	if (src == refDestM && refTnewM == 2'd0)
		return hazardPkg::fwdM;
	if (src == refDestW)
		return hazardPkg::fwdW;
	return hazardPkg::fwdReg;
endfunction

`endif

// ==== sim/hazardUnitTb.sv ====
module hazardUnitTb;
	timeunit 1ns;
	timeprecision 1ps;

	`include "hazardRef.svh"

	logic              clk;
	logic              rstN;
	isaPkg::instrT     instrD;
	logic              stall;
	hazardPkg::fwdSelT fwdRsD;
	hazardPkg::fwdSelT fwdRtD;
	hazardPkg::fwdSelT fwdRsE;
	hazardPkg::fwdSelT fwdRtE;

	isaPkg::instrT prog[$];
	int            testStart[$];
	string         testName[$];
	string         curTest;
	int            seed = 72727;
	int            errors = 0;
	int            testErrors = 0;
	int            checks = 0;
	int            cycles = 0;
	int            cycleLimit = 0;
	logic          running = 1'b0;
	logic          holdNext = 1'b0;

	hazardUnit dut_i (
		.clk(clk), .rstN(rstN), .instrD(instrD), .stall(stall),
		.fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// Instruction builders
	//////////////////////////////
	function automatic isaPkg::instrT rType(input logic [5:0] fn, input isaPkg::regNumT rs,
			input isaPkg::regNumT rt, input isaPkg::regNumT rd);
		return {isaPkg::opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic isaPkg::instrT iType(input logic [5:0] op, input isaPkg::regNumT rs,
			input isaPkg::regNumT rt);
		return {op, rs, rt, 16'h0010};
	endfunction

	// Registers 0 to 3 only so hazards come often
	function automatic isaPkg::instrT randomInstr();
		logic [31:0]    r;
		isaPkg::regNumT a;
		isaPkg::regNumT b;
		isaPkg::regNumT c;
		r = $random(seed);
		a = {3'd0, r[5:4]};
		b = {3'd0, r[7:6]};
		c = {3'd0, r[9:8]};
		case (r[3:0])
			4'd0: return rType(isaPkg::fnAddu, a, b, c);
			4'd1: return rType(isaPkg::fnSubu, a, b, c);
			4'd2: return rType(isaPkg::fnAnd, a, b, c);
			4'd3: return rType(isaPkg::fnSlt, a, b, c);
			4'd4: return rType(isaPkg::fnJr, a, 5'd0, 5'd0);
			4'd5: return iType(isaPkg::opOri, a, b);
			4'd6: return iType(isaPkg::opAddi, a, b);
			4'd7: return iType(isaPkg::opLui, 5'd0, b);
			4'd8: return iType(isaPkg::opLw, a, b);
			4'd9: return iType(isaPkg::opLb, a, b);
			4'd10: return iType(isaPkg::opLh, a, b);
			4'd11: return iType(isaPkg::opSw, a, b);
			4'd12: return iType(isaPkg::opSb, a, b);
			4'd13: return iType(isaPkg::opBeq, a, b);
			4'd14: return {isaPkg::opJ, 26'h40};
			default: return {isaPkg::opJal, 26'h80};
		endcase
	endfunction

	task automatic beginTest(input string name);
		testName.push_back(name);
		testStart.push_back(prog.size());
	endtask

	// Drain the pipe so tests do not overlap
	task automatic endTest();
		repeat (3) prog.push_back('0);
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic checkStall(input logic expected, input logic actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			testErrors++;
			$display("Mismatch %s stall expected=%b actual=%b", curTest, expected, actual);
		end
	endtask

	task automatic checkFwd(input string what, input hazardPkg::fwdSelT expected,
			input hazardPkg::fwdSelT actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			testErrors++;
			$display("Mismatch %s %s expected=%s actual=%s", curTest, what,
				expected.name(), actual.name());
		end
	endtask

	// Checks mid low phase and steps the model across the next rising edge
	initial begin
		isaPkg::regNumT  dDest;
		hazardPkg::tnewT dTnew;
		hazardPkg::tuseT useRs;
		hazardPkg::tuseT useRt;
		isaPkg::regNumT  rsD;
		isaPkg::regNumT  rtD;
		logic            expStall;
		forever begin
			@(negedge clk);
			#5;
			if (running) begin
				rsD = instrD[25:21];
				rtD = instrD[20:16];
				producerInfo(instrD, dDest, dTnew);
				consumerUse(instrD, useRs, useRt);
				expStall = operandWaits(rsD, useRs) || operandWaits(rtD, useRt);
				checkStall(expStall, stall);
				checkFwd("fwdRsD", newestSource(rsD, 1'b1), fwdRsD);
				checkFwd("fwdRtD", newestSource(rtD, 1'b1), fwdRtD);
				checkFwd("fwdRsE", newestSource(refRsE, 1'b0), fwdRsE);
				checkFwd("fwdRtE", newestSource(refRtE, 1'b0), fwdRtE);
				refDestW = refDestM;
				refDestM = refDestE;
				refTnewM = (refTnewE == 2'd0) ? 2'd0 : refTnewE - 2'd1;
				refDestE = expStall ? 5'd0 : dDest;
				refTnewE = expStall ? 2'd0 : dTnew;
				refRsE   = expStall ? 5'd0 : rsD;
				refRtE   = expStall ? 5'd0 : rtD;
				holdNext = expStall;
			end
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycleLimit > 0 && cycles > cycleLimit) begin
				$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
				$display("STATUS: FAIL");
				$finish;
			end
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		int t;
		rstN = 1'b0;
		instrD = '0;
		refDestE = '0;
		refDestM = '0;
		refDestW = '0;
		refRsE = '0;
		refRtE = '0;
		refTnewE = '0;
		refTnewM = '0;

		beginTest("independentAlu");
		prog.push_back(rType(isaPkg::fnAddu, 5'd2, 5'd3, 5'd1));
		prog.push_back(iType(isaPkg::opOri, 5'd5, 5'd4));
		prog.push_back(rType(isaPkg::fnSubu, 5'd7, 5'd8, 5'd6));
		endTest();
		beginTest("loadUse");
		prog.push_back(iType(isaPkg::opLw, 5'd1, 5'd5));
		prog.push_back(rType(isaPkg::fnAddu, 5'd2, 5'd5, 5'd6));
		endTest();
		beginTest("branchAndJr");
		prog.push_back(rType(isaPkg::fnAddu, 5'd1, 5'd2, 5'd3));
		prog.push_back(iType(isaPkg::opBeq, 5'd3, 5'd0));
		prog.push_back({isaPkg::opJal, 26'h100});
		prog.push_back(rType(isaPkg::fnJr, 5'd31, 5'd0, 5'd0));
		endTest();
		beginTest("registerZero");
		prog.push_back(rType(isaPkg::fnAddu, 5'd1, 5'd2, 5'd0));
		prog.push_back(rType(isaPkg::fnAddu, 5'd0, 5'd0, 5'd4));
		prog.push_back(iType(isaPkg::opLw, 5'd1, 5'd0));
		prog.push_back(iType(isaPkg::opBeq, 5'd0, 5'd0));
		endTest();
		beginTest("storeAfterLoad");
		prog.push_back(iType(isaPkg::opLw, 5'd1, 5'd7));
		prog.push_back(iType(isaPkg::opSw, 5'd2, 5'd7));
		endTest();
		beginTest("random");
		repeat (200) prog.push_back(randomInstr());
		endTest();

		// Each instruction may stall at most twice
		cycleLimit = prog.size() * 3 + 10;

		repeat (3) @(negedge clk);
		rstN = 1'b1;
		running = 1'b1;
		t = 0;
		for (int i = 0; i < prog.size(); i++) begin
			if (t < testStart.size() && i == testStart[t]) begin
				if (t > 0)
					$display("Test %s finished with %0d errors", curTest, testErrors);
				curTest = testName[t];
				testErrors = 0;
				t++;
			end
			instrD = prog[i];
			@(negedge clk);
			while (holdNext)
				@(negedge clk);
		end
		$display("Test %s finished with %0d errors", curTest, testErrors);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== verilog/forwardSelect.sv ====
module forwardSelect (
	input  isaPkg::regNumT     rsD,
	input  isaPkg::regNumT     rtD,
	input  isaPkg::regNumT     rsE,
	input  isaPkg::regNumT     rtE,
	input  isaPkg::regNumT     destE,
	input  isaPkg::regNumT     destM,
	input  isaPkg::regNumT     destW,
	input  hazardPkg::tnewT    tnewE,
	input  hazardPkg::tnewT    tnewM,
	output hazardPkg::fwdSelT  fwdRsD,
	output hazardPkg::fwdSelT  fwdRtD,
	output hazardPkg::fwdSelT  fwdRsE,
	output hazardPkg::fwdSelT  fwdRtE
);

	// Newest ready producer wins
	// Register 0 never forwards
	function automatic hazardPkg::fwdSelT pickSrc(
		input isaPkg::regNumT src,
		input logic           checkE
	);
		hazardPkg::fwdSelT sel;
		sel = hazardPkg::fwdReg;
		if (src != '0) begin
			if (checkE && src == destE && tnewE == hazardPkg::tnewNone)
				sel = hazardPkg::fwdE;
			else if (src == destM && tnewM == hazardPkg::tnewNone)
				sel = hazardPkg::fwdM;
			// W result is always ready
			else if (src == destW)
				sel = hazardPkg::fwdW;
		end
		pickSrc = sel;
	endfunction

	//////////////////////////////
	// Operands read in D
	//////////////////////////////
	always_comb begin
		fwdRsD = pickSrc(rsD, 1'b1);
		fwdRtD = pickSrc(rtD, 1'b1);
	end

	//////////////////////////////
	// Operands used in E
	//////////////////////////////
	// Only M and W are older than E
	always_comb begin
		fwdRsE = pickSrc(rsE, 1'b0);
		fwdRtE = pickSrc(rtE, 1'b0);
	end

endmodule

// ==== verilog/hazardPipe.sv ====
module hazardPipe (
	input  logic              clk,
	input  logic              rstN,
	input  logic              stall,
	input  isaPkg::regNumT    destD,
	input  hazardPkg::tnewT   tnewD,
	input  isaPkg::regNumT    rsD,
	input  isaPkg::regNumT    rtD,
	output isaPkg::regNumT    destE,
	output isaPkg::regNumT    destM,
	output isaPkg::regNumT    destW,
	output isaPkg::regNumT    rsE,
	output isaPkg::regNumT    rtE,
	output hazardPkg::tnewT   tnewE,
	output hazardPkg::tnewT   tnewM
);

	hazardPkg::tnewT tnewDec;

	// One stage older, never below zero
	assign tnewDec = (tnewE == hazardPkg::tnewNone) ? hazardPkg::tnewNone : tnewE - 2'd1;

	//////////////////////////////
	// E stage
	//////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			destE <= '0;
			tnewE <= hazardPkg::tnewNone;
			rsE   <= '0;
			rtE   <= '0;
		end else if (stall) begin
			// Bubble, D holds its instruction
			destE <= '0;
			tnewE <= hazardPkg::tnewNone;
			rsE   <= '0;
			rtE   <= '0;
		end else begin
			destE <= destD;
			tnewE <= tnewD;
			rsE   <= rsD;
			rtE   <= rtD;
		end
	end

	//////////////////////////////
	// M and W stages
	//////////////////////////////
	// These advance even during a stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			destM <= '0;
			tnewM <= hazardPkg::tnewNone;
			destW <= '0;
		end else begin
			destM <= destE;
			tnewM <= tnewDec;
			destW <= destM;
		end
	end

endmodule

// ==== verilog/hazardPkg.sv ====
package hazardPkg;

	// Cycles until a result exists
	typedef logic [1:0] tnewT;

	// Cycles until an operand is consumed
	typedef logic [1:0] tuseT;

	localparam tnewT tnewNone = 2'd0;
	localparam tnewT tnewAlu  = 2'd1;
	localparam tnewT tnewLoad = 2'd2;

	// Tuse counted from D
	localparam tuseT tuseD  = 2'd0;
	localparam tuseT tuseE  = 2'd1;
	localparam tuseT tuseM  = 2'd2;
	// Operand not read at all
	localparam tuseT noUse  = 2'd3;

	// Operand source, register file or a later stage
	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdE   = 2'd1,
		fwdM   = 2'd2,
		fwdW   = 2'd3
	} fwdSelT;

endpackage

// ==== verilog/hazardUnit.sv ====
module hazardUnit (
	input  logic               clk,
	input  logic               rstN,
	input  isaPkg::instrT      instrD,
	output logic               stall,
	output hazardPkg::fwdSelT  fwdRsD,
	output hazardPkg::fwdSelT  fwdRtD,
	output hazardPkg::fwdSelT  fwdRsE,
	output hazardPkg::fwdSelT  fwdRtE
);

	// D stage decode
	isaPkg::regNumT  rsD;
	isaPkg::regNumT  rtD;
	hazardPkg::tuseT tuseRs;
	hazardPkg::tuseT tuseRt;
	isaPkg::regNumT  destD;
	hazardPkg::tnewT tnewD;

	// Tracked producers and E operands
	isaPkg::regNumT  destE;
	isaPkg::regNumT  destM;
	isaPkg::regNumT  destW;
	isaPkg::regNumT  rsE;
	isaPkg::regNumT  rtE;
	hazardPkg::tnewT tnewE;
	hazardPkg::tnewT tnewM;

	useDecode useDec (
		.instr(instrD), .rs(rsD), .rt(rtD), .tuseRs(tuseRs), .tuseRt(tuseRt)
	);

	writeDecode writeDec (
		.instr(instrD), .dest(destD), .tnew(tnewD)
	);

	hazardPipe pipe (
		.clk(clk), .rstN(rstN), .stall(stall),
		.destD(destD), .tnewD(tnewD), .rsD(rsD), .rtD(rtD),
		.destE(destE), .destM(destM), .destW(destW),
		.rsE(rsE), .rtE(rtE), .tnewE(tnewE), .tnewM(tnewM)
	);

	stallCheck stallChk (
		.rs(rsD), .rt(rtD), .tuseRs(tuseRs), .tuseRt(tuseRt),
		.destE(destE), .destM(destM), .tnewE(tnewE), .tnewM(tnewM),
		.stall(stall)
	);

	forwardSelect fwdSel (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
		.destE(destE), .destM(destM), .destW(destW),
		.tnewE(tnewE), .tnewM(tnewM),
		.fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE)
	);

endmodule

// ==== verilog/isaPkg.sv ====
package isaPkg;

	typedef logic [31:0] instrT;
	typedef logic [4:0]  regNumT;

	//////////////////////////////
	// Instruction fields
	//////////////////////////////
	localparam int opMsb = 31;
	localparam int opLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;
	localparam int fnMsb = 5;
	localparam int fnLsb = 0;

	// Destination of jal
	localparam regNumT linkReg = 5'd31;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	localparam logic [5:0] opR    = 6'b000000;
	localparam logic [5:0] opOri  = 6'b001101;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opLui  = 6'b001111;
	localparam logic [5:0] opLw   = 6'b100011;
	localparam logic [5:0] opLb   = 6'b100000;
	localparam logic [5:0] opLh   = 6'b100001;
	localparam logic [5:0] opSw   = 6'b101011;
	localparam logic [5:0] opSb   = 6'b101000;
	localparam logic [5:0] opSh   = 6'b101001;
	localparam logic [5:0] opBeq  = 6'b000100;
	localparam logic [5:0] opJ    = 6'b000010;
	localparam logic [5:0] opJal  = 6'b000011;

	// Function codes, R-type only
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;
	localparam logic [5:0] fnJr   = 6'b001000;

endpackage

// ==== verilog/stallCheck.sv ====
module stallCheck (
	input  isaPkg::regNumT    rs,
	input  isaPkg::regNumT    rt,
	input  hazardPkg::tuseT   tuseRs,
	input  hazardPkg::tuseT   tuseRt,
	input  isaPkg::regNumT    destE,
	input  isaPkg::regNumT    destM,
	input  hazardPkg::tnewT   tnewE,
	input  hazardPkg::tnewT   tnewM,
	output logic              stall
);

	// Operand still waiting on a producer in E or M
	function automatic logic mustWait(
		input isaPkg::regNumT  src,
		input hazardPkg::tuseT tuse
	);
		logic hitE;
		logic hitM;
		hitE = (src == destE) && (tuse < tnewE);
		hitM = (src == destM) && (tuse < tnewM);
		mustWait = (src != '0) && (tuse != hazardPkg::noUse) && (hitE || hitM);
	endfunction

	logic waitRs;
	logic waitRt;

	always_comb begin
		waitRs = mustWait(rs, tuseRs);
		waitRt = mustWait(rt, tuseRt);
	end

	// Either operand holds D
	assign stall = waitRs | waitRt;

endmodule

// ==== verilog/useDecode.sv ====
module useDecode (
	input  isaPkg::instrT     instr,
	output isaPkg::regNumT    rs,
	output isaPkg::regNumT    rt,
	output hazardPkg::tuseT   tuseRs,
	output hazardPkg::tuseT   tuseRt
);

	logic [5:0] op;
	logic [5:0] fn;

	assign op = instr[isaPkg::opMsb:isaPkg::opLsb];
	assign fn = instr[isaPkg::fnMsb:isaPkg::fnLsb];

	// Raw fields, qualified later by Tuse
	assign rs = instr[isaPkg::rsMsb:isaPkg::rsLsb];
	assign rt = instr[isaPkg::rtMsb:isaPkg::rtLsb];

	always_comb begin
		tuseRs = hazardPkg::noUse;
		tuseRt = hazardPkg::noUse;
		case (op)
			isaPkg::opR: begin
				case (fn)
					isaPkg::fnAddu, isaPkg::fnSubu, isaPkg::fnAnd,
					isaPkg::fnOr, isaPkg::fnSlt, isaPkg::fnSltu: begin
						tuseRs = hazardPkg::tuseE;
						tuseRt = hazardPkg::tuseE;
					end
					// Jump target needed in D
					isaPkg::fnJr: tuseRs = hazardPkg::tuseD;
					default: tuseRs = hazardPkg::noUse;
				endcase
			end

			// Compare done in D
			isaPkg::opBeq: begin
				tuseRs = hazardPkg::tuseD;
				tuseRt = hazardPkg::tuseD;
			end

			// Base or source operand in E
			isaPkg::opOri, isaPkg::opAddi, isaPkg::opAndi,
			isaPkg::opLw, isaPkg::opLb, isaPkg::opLh: begin
				tuseRs = hazardPkg::tuseE;
			end

			// Store data only needed once the store reaches M
			isaPkg::opSw, isaPkg::opSb, isaPkg::opSh: begin
				tuseRs = hazardPkg::tuseE;
				tuseRt = hazardPkg::tuseM;
			end

			// lui, j and jal read no registers
			isaPkg::opLui, isaPkg::opJ, isaPkg::opJal: begin
				tuseRs = hazardPkg::noUse;
				tuseRt = hazardPkg::noUse;
			end

			default: tuseRs = hazardPkg::noUse;
		endcase
	end

endmodule

// ==== verilog/writeDecode.sv ====
module writeDecode (
	input  isaPkg::instrT     instr,
	output isaPkg::regNumT    dest,
	output hazardPkg::tnewT   tnew
);

	logic [5:0]     op;
	logic [5:0]     fn;
	isaPkg::regNumT rtF;
	isaPkg::regNumT rdF;

	assign op  = instr[isaPkg::opMsb:isaPkg::opLsb];
	assign fn  = instr[isaPkg::fnMsb:isaPkg::fnLsb];
	assign rtF = instr[isaPkg::rtMsb:isaPkg::rtLsb];
	assign rdF = instr[isaPkg::rdMsb:isaPkg::rdLsb];

	// Tnew seen once the instruction sits in E
	always_comb begin
		case (op)
			isaPkg::opR: begin
				case (fn)
					isaPkg::fnAddu, isaPkg::fnSubu, isaPkg::fnAnd,
					isaPkg::fnOr, isaPkg::fnSlt, isaPkg::fnSltu: begin
						dest = rdF;
						tnew = hazardPkg::tnewAlu;
					end
					// jr and unknown functions write nothing
					default: begin
						dest = '0;
						tnew = hazardPkg::tnewNone;
					end
				endcase
			end

			// I-type ALU and lui, result after E
			isaPkg::opOri, isaPkg::opAddi, isaPkg::opAndi, isaPkg::opLui: begin
				dest = rtF;
				tnew = hazardPkg::tnewAlu;
			end

			// Loads, data arrives after M
			isaPkg::opLw, isaPkg::opLb, isaPkg::opLh: begin
				dest = rtF;
				tnew = hazardPkg::tnewLoad;
			end

			// Return address is known as soon as jal decodes
			isaPkg::opJal: begin
				dest = isaPkg::linkReg;
				tnew = hazardPkg::tnewNone;
			end

			// Stores, beq and j have no register result
			isaPkg::opSw, isaPkg::opSb, isaPkg::opSh,
			isaPkg::opBeq, isaPkg::opJ: begin
				dest = '0;
				tnew = hazardPkg::tnewNone;
			end

			default: begin
				dest = '0;
				tnew = hazardPkg::tnewNone;
			end
		endcase
	end

endmodule
